// File: verilog/lz_prc_pkg.sv
// Shared widths, TLV codes and encodings for the LZ77 compressor front end
// Every width is fixed by the 64-bit TLV word format
// Types above 31 have no entry in the action map and are always deleted
package lz_prc_pkg;

   typedef logic [63:0] tlv_data_t;
   typedef logic [7:0]  tlv_strb_t;    // Bit i marks byte i
   typedef logic [7:0]  tlv_type_t;
   typedef logic [31:0] sample_t;
   typedef logic [3:0]  sample_vld_t;
   typedef logic [7:0]  err_code_t;
   typedef logic [5:0]  credit_t;
   typedef logic [63:0] action_map_t;  // 2 bits per type, type n at bits 2n+1:2n
   typedef logic [1:0]  tlv_act_t;

   localparam tlv_type_t TYPE_CMD      = 8'd1;
   localparam tlv_type_t TYPE_DATA     = 8'd4;
   localparam tlv_type_t TYPE_DATA_UNK = 8'd5;
   localparam tlv_type_t TYPE_FTR      = 8'd7;

   localparam int       ACT_TYPES  = 32;   // Types covered by the action map
   localparam tlv_act_t ACT_MODIFY = 2'd0; // Forward, any other code deletes
   localparam tlv_act_t ACT_DELETE = 2'd1;

   localparam credit_t OUT_CREDITS = 6'd32;

   // Field positions in command word 2 and the footer's last word
   localparam int CMD_MODE_LSB = 0;
   localparam int CMD_WIN_LSB  = 4;
   localparam int FTR_ERR_LSB  = 0;

   typedef enum logic [3:0] {
      NONE  = 4'd0,
      ZLIB  = 4'd1,
      GZIP  = 4'd2,
      XP9   = 4'd3,
      XP10  = 4'd4,
      CHU4K = 4'd5,
      CHU8K = 4'd6
   } comp_mode_e;

   typedef enum logic [2:0] {
      WIN_32B = 3'd0,
      WIN_4K  = 3'd1,
      WIN_8K  = 3'd2,
      WIN_16K = 3'd3,
      WIN_32K = 3'd4,
      WIN_64K = 3'd5
   } win_size_e;

   localparam err_code_t ERR_NONE         = 8'd0;
   localparam err_code_t ERR_BAD_COMP_ALG = 8'd1;
   localparam err_code_t ERR_BAD_WIN_SIZE = 8'd2;

   typedef enum logic [2:0] {
      ST_WORD_ZERO,
      ST_CMD,
      ST_DATA_LO,
      ST_DATA_HI,
      ST_FOOTER,
      ST_BYPASS
   } prc_state_e;

endpackage

// File: verilog/lz_prc_ifs.sv
// Buses inside the front end, no clock or handshake of their own
// tlv_word_if holds the head word of the input queue
// sample_wr_if is a single-cycle write strobe into the sample queue
interface tlv_word_if;
   import lz_prc_pkg::*;

   tlv_data_t tdata;
   tlv_strb_t tstrb;
   tlv_type_t typ;
   logic      eot;

   modport src  (output tdata, tstrb, typ, eot);
   modport sink (input  tdata, tstrb, typ, eot);
endinterface

interface sample_wr_if;
   import lz_prc_pkg::*;

   logic        wen;
   logic        hi_half;   // Bytes 7..4 of the word instead of 3..0
   sample_vld_t vld_mask;  // Strobes of the selected half, word order
   logic        eot;

   modport ctrl  (output wen, hi_half, vld_mask, eot);
   modport queue (input  wen, hi_half, vld_mask, eot);
endinterface

// File: verilog/tlv_frame_ctrl.sv
// Parse FSM for the TLV stream, o_rd and o_out_valid are combinational
// The action of word zero is held for the whole TLV
// Samples are only written while the sample queue has room
module tlv_frame_ctrl (
   input  logic                    clk,
   input  logic                    rst_n,
   tlv_word_if.sink                tlv,
   input  logic                    i_empty,
   input  lz_prc_pkg::action_map_t i_action_map,
   input  logic                    i_out_credit,
   input  logic                    i_compress_en,
   input  logic                    i_queue_full,
   sample_wr_if.ctrl               wr,
   output logic                    o_rd,
   output logic                    o_out_valid,
   output logic                    o_out_compressed,
   output logic                    o_cmd_w2_take,
   output logic                    o_footer_last
);
   import lz_prc_pkg::*;

   prc_state_e state;
   prc_state_e state_nxt;
   tlv_act_t   act_lkup;
   tlv_act_t   act_q;
   credit_t    credit;
   logic       cmd_second;  // Next command word is word 2
   logic       have_credit;
   logic       fwd_q;
   logic       pass_ok;
   logic       is_data;

   // Action lookup from word zero's type
   always_comb begin
      if (tlv.typ < ACT_TYPES)
         act_lkup = i_action_map[{tlv.typ[4:0], 1'b0} +: 2];
      else
         act_lkup = ACT_DELETE;
   end

   assign have_credit = |credit;
   assign fwd_q       = (act_q == ACT_MODIFY);
   assign pass_ok     = !fwd_q || have_credit;  // Deleted words need no credit
   assign is_data     = (tlv.typ == TYPE_DATA) || (tlv.typ == TYPE_DATA_UNK);

   always_comb begin
      state_nxt        = state;
      o_rd             = 1'b0;
      o_out_valid      = 1'b0;
      o_out_compressed = 1'b0;
      o_cmd_w2_take    = 1'b0;
      o_footer_last    = 1'b0;
      wr.wen           = 1'b0;
      wr.hi_half       = 1'b0;
      wr.vld_mask      = tlv.tstrb[3:0];
      wr.eot           = 1'b0;

      case (state)
         ST_WORD_ZERO: begin
            if (!i_empty && ((act_lkup != ACT_MODIFY) || have_credit)) begin
               o_rd             = 1'b1;
               o_out_valid      = (act_lkup == ACT_MODIFY);
               o_out_compressed = o_out_valid && is_data && i_compress_en;
               if (!tlv.eot) begin
                  if (tlv.typ == TYPE_CMD)
                     state_nxt = ST_CMD;
                  else if (is_data)
                     state_nxt = ST_DATA_LO;
                  else if (tlv.typ == TYPE_FTR)
                     state_nxt = ST_FOOTER;
                  else
                     state_nxt = ST_BYPASS;
               end
            end
         end
         ST_CMD: begin
            if (!i_empty && pass_ok) begin
               o_rd          = 1'b1;
               o_out_valid   = fwd_q;
               o_cmd_w2_take = cmd_second;
               if (tlv.eot)
                  state_nxt = ST_WORD_ZERO;
            end
         end
         ST_DATA_LO: begin
            if (!i_empty) begin
               if (fwd_q && i_compress_en) begin
                  if (!i_queue_full) begin
                     wr.wen = 1'b1;
                     if (|tlv.tstrb[7:4]) begin
                        state_nxt = ST_DATA_HI;  // Word stays at the head
                     end else begin
                        o_rd   = 1'b1;
                        wr.eot = tlv.eot;
                        if (tlv.eot)
                           state_nxt = ST_WORD_ZERO;
                     end
                  end
               end else if (pass_ok) begin
                  o_rd        = 1'b1;
                  o_out_valid = fwd_q;
                  if (tlv.eot)
                     state_nxt = ST_WORD_ZERO;
               end
            end
         end
         ST_DATA_HI: begin
            if (!i_queue_full) begin
               wr.wen      = 1'b1;
               wr.hi_half  = 1'b1;
               wr.vld_mask = tlv.tstrb[7:4];
               wr.eot      = tlv.eot;
               o_rd        = 1'b1;
               state_nxt   = tlv.eot ? ST_WORD_ZERO : ST_DATA_LO;
            end
         end
         default: begin
            // Footer and bypass words
            if (!i_empty && pass_ok) begin
               o_rd          = 1'b1;
               o_out_valid   = fwd_q;
               o_footer_last = fwd_q && tlv.eot && (state == ST_FOOTER);
               if (tlv.eot)
                  state_nxt = ST_WORD_ZERO;
            end
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= ST_WORD_ZERO;
         act_q      <= ACT_MODIFY;
         credit     <= OUT_CREDITS;
         cmd_second <= 1'b0;
      end else begin
         state <= state_nxt;
         if ((state == ST_WORD_ZERO) && o_rd)
            act_q <= act_lkup;
         if (o_out_valid && !i_out_credit)
            credit <= credit - 1'b1;
         else if (!o_out_valid && i_out_credit)
            credit <= credit + 1'b1;
         if ((state == ST_CMD) && o_rd)
            cmd_second <= !cmd_second && !tlv.eot;  // Back to word 1 after eot
      end
   end

endmodule

// File: verilog/comp_cfg_check.sv
// Captures mode and window from command word 2 and checks them
// Settings and error update on the clock after word 2 is read
// The pending error is cleared by the last forwarded footer word
module comp_cfg_check (
   input  logic                  clk,
   input  logic                  rst_n,
   tlv_word_if.sink              tlv,
   input  logic                  i_cmd_w2_take,
   input  logic                  i_footer_last,
   output logic                  o_compress_en,
   output lz_prc_pkg::win_size_e o_win_size,
   output lz_prc_pkg::err_code_t o_err_code
);
   import lz_prc_pkg::*;

   comp_mode_e cmd_mode;
   win_size_e  cmd_win;
   logic       bad_alg;
   logic       bad_win;

   function automatic logic win_invalid(input comp_mode_e mode, input win_size_e win);
      logic bad;
      if (win == WIN_32B)
         bad = 1'b0;
      else if (win > WIN_64K)
         bad = 1'b1;
      else begin
         case (mode)
            NONE:       bad = 1'b0;
            ZLIB, GZIP: bad = (win != WIN_32K);
            XP9:        bad = (win != WIN_64K);
            CHU4K:      bad = (win != WIN_4K);
            CHU8K:      bad = (win != WIN_8K);
            XP10:       bad = (win == WIN_32K);
            default:    bad = 1'b0;  // Bad mode is reported first anyway
         endcase
      end
      return bad;
   endfunction

   assign cmd_mode = comp_mode_e'(tlv.tdata[CMD_MODE_LSB +: $bits(comp_mode_e)]);
   assign cmd_win  = win_size_e'(tlv.tdata[CMD_WIN_LSB +: $bits(win_size_e)]);
   assign bad_alg  = (cmd_mode > CHU8K);
   assign bad_win  = win_invalid(cmd_mode, cmd_win);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         o_compress_en <= 1'b0;
         o_win_size    <= WIN_32B;
         o_err_code    <= ERR_NONE;
      end else if (i_cmd_w2_take) begin
         o_compress_en <= (cmd_mode != NONE) && !bad_alg;
         o_win_size    <= cmd_win;
         o_err_code    <= bad_alg ? ERR_BAD_COMP_ALG :
                          bad_win ? ERR_BAD_WIN_SIZE : ERR_NONE;
      end else if (i_footer_last) begin
         o_err_code <= ERR_NONE;
      end
   end

endmodule

// File: verilog/footer_patch.sv
// Output word mux, combinational in the read cycle
// A footer that already carries an error keeps its own code
module footer_patch (
   tlv_word_if.sink              tlv,
   input  logic                  i_footer_last,
   input  lz_prc_pkg::err_code_t i_err_code,
   output lz_prc_pkg::tlv_data_t o_out_data,
   output lz_prc_pkg::tlv_strb_t o_out_strb,
   output lz_prc_pkg::tlv_type_t o_out_type,
   output logic                  o_out_eot
);
   import lz_prc_pkg::*;

   err_code_t ftr_err;
   logic      patch;

   assign ftr_err = tlv.tdata[FTR_ERR_LSB +: $bits(err_code_t)];
   assign patch   = i_footer_last && (i_err_code != ERR_NONE) && (ftr_err == ERR_NONE);

   always_comb begin
      o_out_data = tlv.tdata;
      if (patch)
         o_out_data[FTR_ERR_LSB +: $bits(err_code_t)] = i_err_code;
   end

   assign o_out_strb = tlv.tstrb;
   assign o_out_type = tlv.typ;
   assign o_out_eot  = tlv.eot;

endmodule

// File: verilog/lec_sample_queue.sv
// Two-entry sample queue towards the match engine
// Writer must not write while o_full is high
// Outputs are registered, o_lec_sample_vld is zero outside a pop cycle
module lec_sample_queue (
   input  logic                    clk,
   input  logic                    rst_n,
   tlv_word_if.sink                tlv,
   sample_wr_if.queue              wr,
   input  logic                    i_lec_stall,
   output logic                    o_full,
   output lz_prc_pkg::sample_t     o_lec_sample_data,
   output lz_prc_pkg::sample_vld_t o_lec_sample_vld,
   output logic                    o_lec_sample_eot
);
   import lz_prc_pkg::*;

   sample_t     half;
   sample_t     wdata;
   sample_vld_t wvld;
   sample_t     q_data [2];
   sample_vld_t q_vld  [2];
   logic [1:0]  q_eot;
   logic        wr_ptr;
   logic        rd_ptr;
   logic [1:0]  count;
   logic        pop;

   assign half = wr.hi_half ? tlv.tdata[63:32] : tlv.tdata[31:0];

   // Lowest byte of the half lands in bits 31:24
   always_comb begin
      for (int i = 0; i < 4; i++) begin
         wdata[31 - 8*i -: 8] = half[8*i +: 8];
         wvld[3 - i]          = wr.vld_mask[i];
      end
   end

   assign o_full = (count == 2'd2);
   assign pop    = (count != 2'd0) && !i_lec_stall;

   always_ff @(posedge clk) begin
      if (wr.wen) begin
         q_data[wr_ptr] <= wdata;
         q_vld[wr_ptr]  <= wvld;
         q_eot[wr_ptr]  <= wr.eot;
      end
      if (pop)
         o_lec_sample_data <= q_data[rd_ptr];
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr           <= 1'b0;
         rd_ptr           <= 1'b0;
         count            <= 2'd0;
         o_lec_sample_vld <= '0;
         o_lec_sample_eot <= 1'b0;
      end else begin
         if (wr.wen)
            wr_ptr <= !wr_ptr;
         if (pop)
            rd_ptr <= !rd_ptr;
         case ({wr.wen, pop})
            2'b10:   count <= count + 2'd1;
            2'b01:   count <= count - 2'd1;
            default: count <= count;
         endcase
         o_lec_sample_vld <= pop ? q_vld[rd_ptr] : '0;
         o_lec_sample_eot <= pop && q_eot[rd_ptr];
      end
   end

endmodule

// File: verilog/lz_prc_top.sv
// LZ77 compressor front end, input is a first-word-fall-through queue
// o_rd and o_out_valid pulse in the cycle that consumes the word
// Match engine back-pressure is the level i_lec_stall only
module lz_prc_top (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    i_empty,
   input  lz_prc_pkg::tlv_data_t   i_tlv_data,
   input  lz_prc_pkg::tlv_strb_t   i_tlv_strb,
   input  lz_prc_pkg::tlv_type_t   i_tlv_type,
   input  logic                    i_tlv_eot,
   input  lz_prc_pkg::action_map_t i_action_map,
   input  logic                    i_out_credit,
   input  logic                    i_lec_stall,
   output logic                    o_rd,
   output logic                    o_out_valid,
   output lz_prc_pkg::tlv_data_t   o_out_data,
   output lz_prc_pkg::tlv_strb_t   o_out_strb,
   output lz_prc_pkg::tlv_type_t   o_out_type,
   output logic                    o_out_eot,
   output logic                    o_out_compressed,
   output lz_prc_pkg::sample_t     o_lec_sample_data,
   output lz_prc_pkg::sample_vld_t o_lec_sample_vld,
   output logic                    o_lec_sample_eot,
   output lz_prc_pkg::win_size_e   o_lec_win_size
);
   import lz_prc_pkg::*;

   tlv_word_if  tlv_bus ();
   sample_wr_if wr_bus ();

   logic      compress_en;
   logic      queue_full;
   logic      cmd_w2_take;
   logic      footer_last;
   err_code_t err_code;

   assign tlv_bus.tdata = i_tlv_data;  // Head word of the input queue
   assign tlv_bus.tstrb = i_tlv_strb;
   assign tlv_bus.typ   = i_tlv_type;
   assign tlv_bus.eot   = i_tlv_eot;

   tlv_frame_ctrl u_ctrl (
      .clk(clk), .rst_n(rst_n), .tlv(tlv_bus.sink), .i_empty(i_empty),
      .i_action_map(i_action_map), .i_out_credit(i_out_credit),
      .i_compress_en(compress_en), .i_queue_full(queue_full), .wr(wr_bus.ctrl),
      .o_rd(o_rd), .o_out_valid(o_out_valid), .o_out_compressed(o_out_compressed),
      .o_cmd_w2_take(cmd_w2_take), .o_footer_last(footer_last)
   );

   comp_cfg_check u_cfg (
      .clk(clk), .rst_n(rst_n), .tlv(tlv_bus.sink), .i_cmd_w2_take(cmd_w2_take),
      .i_footer_last(footer_last), .o_compress_en(compress_en),
      .o_win_size(o_lec_win_size), .o_err_code(err_code)
   );

   footer_patch u_ftr (
      .tlv(tlv_bus.sink), .i_footer_last(footer_last), .i_err_code(err_code),
      .o_out_data(o_out_data), .o_out_strb(o_out_strb), .o_out_type(o_out_type),
      .o_out_eot(o_out_eot)
   );

   lec_sample_queue u_lec_q (
      .clk(clk), .rst_n(rst_n), .tlv(tlv_bus.sink), .wr(wr_bus.queue),
      .i_lec_stall(i_lec_stall), .o_full(queue_full),
      .o_lec_sample_data(o_lec_sample_data), .o_lec_sample_vld(o_lec_sample_vld),
      .o_lec_sample_eot(o_lec_sample_eot)
   );

endmodule

// File: tests/tb_lz_prc.sv
// Testbench for lz_prc_top with a FWFT input queue model and a reference model
// Inputs are driven on the falling edge, outputs are checked on the rising edge
// Types 12 and 13 map to deleting actions, every other type below 32 forwards
module tb_lz_prc;
   import lz_prc_pkg::*;

   typedef struct packed {
      tlv_data_t data;
      tlv_strb_t strb;
      tlv_type_t typ;
      logic      eot;
   } word_t;

   typedef struct packed {
      word_t w;
      logic  cmp;
   } out_t;

   typedef struct packed {
      sample_t     data;
      sample_vld_t vld;
      logic        eot;
   } smp_t;

   localparam action_map_t ACTION_MAP = (64'h1 << 24) | (64'h3 << 26);
   localparam int TIMEOUT = 2000;

   logic        clk = 1'b0;
   logic        rst_n;
   logic        i_empty;
   tlv_data_t   i_tlv_data;
   tlv_strb_t   i_tlv_strb;
   tlv_type_t   i_tlv_type;
   logic        i_tlv_eot;
   action_map_t i_action_map;
   logic        i_out_credit;
   logic        i_lec_stall;
   logic        o_rd;
   logic        o_out_valid;
   tlv_data_t   o_out_data;
   tlv_strb_t   o_out_strb;
   tlv_type_t   o_out_type;
   logic        o_out_eot;
   logic        o_out_compressed;
   sample_t     o_lec_sample_data;
   sample_vld_t o_lec_sample_vld;
   logic        o_lec_sample_eot;
   win_size_e   o_lec_win_size;

   word_t in_q[$];
   out_t  exp_out[$];
   smp_t  exp_smp[$];

   // Reference model state, follows the words in push order
   logic      m_compress = 1'b0;
   err_code_t m_err      = ERR_NONE;

   logic  credit_req  = 1'b0;  // Set on the rising edge, driven on the falling one
   logic  credit_due  = 1'b0;
   logic  auto_credit = 1'b0;
   logic  stall_req   = 1'b0;
   int    fwd_cnt = 0;
   int    rd_cnt = 0;
   int    err_cnt = 0;
   int    err_start;
   int    tests_ok = 0;
   int    tests_bad = 0;
   string cur_test = "reset";

   lz_prc_top i_lz_prc_top (.*);

   always #20 clk = ~clk;

   function automatic sample_t byte_rev(input logic [31:0] d);
      return {d[7:0], d[15:8], d[23:16], d[31:24]};
   endfunction

   function automatic sample_vld_t vld_rev(input logic [3:0] s);
      return {s[0], s[1], s[2], s[3]};
   endfunction

   function automatic logic is_forwarded(input tlv_type_t t);
      return (t < 8'd32) && (ACTION_MAP[2*t +: 2] == 2'd0);
   endfunction

   function automatic logic win_allowed(input int mode, input int win);
      if (win == 0)
         return 1'b1;
      if (win > 5)
         return 1'b0;
      case (mode)
         1, 2:    return win == 4;  // ZLIB and GZIP want 32K
         3:       return win == 5;
         4:       return win != 4;
         5:       return win == 1;
         6:       return win == 2;
         default: return 1'b1;
      endcase
   endfunction

   task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
      assert (exp === act) else begin
         $display("ERROR %s: %s expected %0h actual %0h", cur_test, what, exp, act);
         err_cnt++;
      end
   endtask

   // Monitor, combinational outputs still hold the values of the ending cycle
   always @(posedge clk) begin
      out_t ow;
      smp_t sw;
      credit_due = auto_credit && o_out_valid;
      if (rst_n) begin
         if (o_out_valid) begin
            fwd_cnt++;
            assert (o_rd && exp_out.size() > 0) else begin
               $display("ERROR %s: output word seen when none was expected", cur_test);
               err_cnt++;
            end
            if (exp_out.size() > 0) begin
               ow = exp_out.pop_front();
               check_val("out data", ow.w.data, o_out_data);
               check_val("out strb/type/eot/cmp", {ow.w.strb, ow.w.typ, ow.w.eot, ow.cmp},
                         {o_out_strb, o_out_type, o_out_eot, o_out_compressed});
            end
         end
         if (o_rd) begin
            rd_cnt++;
            assert (in_q.size() > 0) else begin
               $display("ERROR %s: read strobe while the input queue is empty", cur_test);
               err_cnt++;
            end
            if (in_q.size() > 0)
               void'(in_q.pop_front());
         end
         if (o_lec_sample_vld != '0) begin
            assert (exp_smp.size() > 0) else begin
               $display("ERROR %s: sample seen when none was expected", cur_test);
               err_cnt++;
            end
            if (exp_smp.size() > 0) begin
               sw = exp_smp.pop_front();
               check_val("sample", {sw.data, sw.vld, sw.eot},
                         {o_lec_sample_data, o_lec_sample_vld, o_lec_sample_eot});
            end
         end
      end
   end

   // Input driver, shows the head of the queue model
   always @(negedge clk) begin
      i_empty = (in_q.size() == 0);
      if (in_q.size() > 0) begin
         i_tlv_data = in_q[0].data;
         i_tlv_strb = in_q[0].strb;
         i_tlv_type = in_q[0].typ;
         i_tlv_eot  = in_q[0].eot;
      end
      i_out_credit = credit_req || credit_due;
      credit_req   = 1'b0;
      i_lec_stall  = stall_req;
   end

   task automatic abort_timeout(input string what);
      $display("ERROR %s: timed out waiting for %s", cur_test, what);
      $display("Simulation FAILED");
      $finish;
   endtask

   task automatic wait_idle();
      int cyc;
      cyc = 0;
      while (in_q.size() != 0 || exp_out.size() != 0 || exp_smp.size() != 0) begin
         @(posedge clk);
         cyc++;
         if (cyc > TIMEOUT)
            abort_timeout("the input queue and expected outputs to drain");
      end
      repeat (4) @(posedge clk);
   endtask

   task automatic wait_forwarded(input int n);
      int cyc;
      cyc = 0;
      while (fwd_cnt < n) begin
         @(posedge clk);
         cyc++;
         if (cyc > TIMEOUT)
            abort_timeout("forwarded words");
      end
   endtask

   task automatic return_credits(input int n);
      repeat (n) begin
         @(posedge clk);
         credit_req = 1'b1;
      end
   endtask

   task automatic push_word(input tlv_data_t d, input tlv_strb_t s, input tlv_type_t t,
                            input logic e, input logic fwd, input logic cmp);
      word_t w;
      out_t  o;
      w.data = d;
      w.strb = s;
      w.typ  = t;
      w.eot  = e;
      in_q.push_back(w);
      o.w   = w;
      o.cmp = cmp;
      if (fwd && is_forwarded(t))
         exp_out.push_back(o);
   endtask

   task automatic send_cmd(input logic [3:0] mode, input logic [2:0] win);
      tlv_data_t d;
      d = {$urandom, $urandom};
      push_word({$urandom, $urandom}, 8'hff, TYPE_CMD, 1'b0, 1'b1, 1'b0);
      push_word({$urandom, $urandom}, 8'hff, TYPE_CMD, 1'b0, 1'b1, 1'b0);
      push_word({d[63:7], win, mode}, 8'hff, TYPE_CMD, 1'b1, 1'b1, 1'b0);
      m_compress = (mode >= 4'd1) && (mode <= 4'd6);
      if (mode > 4'd6)
         m_err = ERR_BAD_COMP_ALG;
      else
         m_err = win_allowed(mode, win) ? ERR_NONE : ERR_BAD_WIN_SIZE;
   endtask

   task automatic send_data(input int n, input tlv_strb_t last_strb);
      tlv_data_t d;
      tlv_strb_t s;
      logic      e;
      smp_t      sm;
      push_word({$urandom, $urandom}, 8'hff, TYPE_DATA, 1'b0, 1'b1, m_compress);
      for (int i = 0; i < n; i++) begin
         d = {$urandom, $urandom};
         e = (i == n - 1);
         s = e ? last_strb : 8'hff;
         push_word(d, s, TYPE_DATA, e, !m_compress, 1'b0);
         if (m_compress) begin
            // A half with no valid byte never shows on the sample outputs
            if (s[3:0] != 4'd0) begin
               sm.data = byte_rev(d[31:0]);
               sm.vld  = vld_rev(s[3:0]);
               sm.eot  = e && (s[7:4] == 4'd0);
               exp_smp.push_back(sm);
            end
            if (s[7:4] != 4'd0) begin
               sm.data = byte_rev(d[63:32]);
               sm.vld  = vld_rev(s[7:4]);
               sm.eot  = e;
               exp_smp.push_back(sm);
            end
         end
      end
   endtask

   task automatic send_footer(input err_code_t last_err);
      tlv_data_t d;
      d = {$urandom, $urandom};
      push_word({$urandom, $urandom}, 8'hff, TYPE_FTR, 1'b0, 1'b1, 1'b0);
      push_word({d[63:8], last_err}, 8'hff, TYPE_FTR, 1'b1, 1'b1, 1'b0);
      if (m_err != ERR_NONE && last_err == ERR_NONE)
         exp_out[exp_out.size() - 1].w.data[7:0] = m_err;
      m_err = ERR_NONE;  // Pending code is consumed by the footer
   endtask

   task automatic start_test(input string name);
      cur_test  = name;
      err_start = err_cnt;
   endtask

   task automatic end_test();
      if (err_cnt == err_start) begin
         tests_ok++;
         $display("test %s: passed", cur_test);
      end else begin
         tests_bad++;
         $display("test %s: failed with %0d errors", cur_test, err_cnt - err_start);
      end
   endtask

   initial begin
      int seed_val;
      int rd_before;
      seed_val     = $urandom(32'h491e);
      rst_n        = 1'b0;
      i_empty      = 1'b1;
      i_tlv_data   = '0;
      i_tlv_strb   = '0;
      i_tlv_type   = '0;
      i_tlv_eot    = 1'b0;
      i_action_map = ACTION_MAP;
      i_out_credit = 1'b0;
      i_lec_stall  = 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk) rst_n = 1'b1;
      @(posedge clk);

      start_test("delete");
      rd_before = rd_cnt;
      push_word({$urandom, $urandom}, 8'hff, 8'd12, 1'b0, 1'b1, 1'b0);
      push_word({$urandom, $urandom}, 8'hff, 8'd12, 1'b0, 1'b1, 1'b0);
      push_word({$urandom, $urandom}, 8'hff, 8'd12, 1'b1, 1'b1, 1'b0);
      push_word({$urandom, $urandom}, 8'hff, 8'd13, 1'b1, 1'b1, 1'b0);
      push_word({$urandom, $urandom}, 8'hff, 8'd40, 1'b1, 1'b1, 1'b0);
      wait_idle();
      check_val("words read", 5, rd_cnt - rd_before);
      check_val("words forwarded", 0, fwd_cnt);
      end_test();

      start_test("credit");
      for (int i = 0; i < 34; i++)
         push_word({$urandom, $urandom}, 8'hff, 8'd9, 1'b1, 1'b1, 1'b0);
      wait_forwarded(32);
      repeat (10) @(posedge clk);
      check_val("forwarded without credit", 32, fwd_cnt);
      check_val("words left in queue", 2, in_q.size());
      credit_req = 1'b1;
      wait_forwarded(33);
      repeat (10) @(posedge clk);
      check_val("forwarded after one credit", 33, fwd_cnt);
      check_val("words left after one credit", 1, in_q.size());
      return_credits(33);
      auto_credit = 1'b1;
      wait_idle();
      end_test();

      start_test("compress");
      send_cmd(4'd4, 3'd3);  // XP10, 16K window
      send_data(3, 8'h0f);
      wait_idle();
      check_val("window size", WIN_16K, o_lec_win_size);
      end_test();

      start_test("bad_config");
      send_cmd(4'd9, 3'd4);
      send_data(2, 8'hff);
      send_footer(ERR_NONE);
      send_cmd(4'd1, 3'd5);  // ZLIB with a 64K window
      send_data(2, 8'h3f);
      send_footer(ERR_NONE);
      wait_idle();
      end_test();

      start_test("footer_keep");
      send_cmd(4'd9, 3'd0);
      send_footer(8'd5);
      send_footer(ERR_NONE);
      send_cmd(4'd4, 3'd1);
      send_footer(ERR_NONE);
      wait_idle();
      end_test();

      start_test("stall");
      send_cmd(4'd4, 3'd3);
      wait_idle();
      @(posedge clk);
      stall_req = 1'b1;
      send_data(6, tlv_strb_t'($urandom_range(1, 255)));
      repeat ($urandom_range(8, 30)) @(posedge clk);
      stall_req = 1'b0;
      wait_idle();
      end_test();

      $display("tests passed %0d, failed %0d, errors %0d", tests_ok, tests_bad, err_cnt);
      if (tests_bad == 0 && err_cnt == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

// File: project.f
verilog/lz_prc_pkg.sv
verilog/lz_prc_ifs.sv
verilog/tlv_frame_ctrl.sv
verilog/comp_cfg_check.sv
verilog/footer_patch.sv
verilog/lec_sample_queue.sv
verilog/lz_prc_top.sv
tests/tb_lz_prc.sv
